//--- tb.f
logic/cache_pkg.sv
logic/cache_tag_store.sv
logic/cache_data_store.sv
logic/cache_fill_unit.sv
logic/cache_ctrl.sv
logic/cache_top.sv
verif/cache_sva.sv
verif/cache_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module cache_tb -f tb.f -o cache_sim
./obj_dir/cache_sim +verilator+error+limit+1000 | tee sim.log
if grep -qF '*** PASSED ***' sim.log; then
  exit 0
fi
exit 1

//--- verif/cache_tb.sv
module cache_tb
  import cache_pkg::*;
;

  // ======================================================================
  // Run length and memory window
  // ======================================================================

  localparam int NUM_TXN        = 400;
  localparam int DIRECTED_OPS   = 20;
  localparam int WINDOW_WORDS   = 512;
  // Worst case of about 200 cycles per transaction
  localparam int TIMEOUT_CYCLES = (NUM_TXN + DIRECTED_OPS) * 200;

  logic        clk;
  logic        rst_n;
  logic        i_rd_valid;
  cache_addr_u i_rd_addr;
  logic        o_rd_ready;
  word_t       o_rd_data;
  logic        o_rd_data_valid;
  logic        i_wr_valid;
  cache_addr_u i_wr_addr;
  word_t       i_wr_data;
  strb_t       i_wr_strb;
  logic        o_wr_ready;
  logic        o_arvalid;
  cache_addr_u o_araddr;
  logic        i_arready;
  logic        i_rvalid;
  word_t       i_rdata;
  logic        i_rlast;
  logic        o_rready;
  logic        o_awvalid;
  cache_addr_u o_awaddr;
  logic        i_awready;
  logic        o_wvalid;
  word_t       o_wdata;
  strb_t       o_wstrb;
  logic        i_wready;

  // Separate random state for stimulus and responder
  logic [15:0] stim_lfsr;
  logic [15:0] resp_lfsr;

  // Reference model
  word_t       model_mem [WINDOW_WORDS];
  tag_t        shadow_tag [NUM_SETS];
  logic        shadow_valid [NUM_SETS];

  // AXI memory and what it saw
  word_t       axi_mem [WINDOW_WORDS];
  logic        burst_on;
  logic [8:0]  burst_line;
  idx_t        beat_idx;
  logic        r_taken;
  logic        aw_seen;
  logic        w_seen;
  cache_addr_u last_araddr;
  cache_addr_u last_awaddr;
  word_t       last_wdata;
  strb_t       last_wstrb;
  int          ar_count = 0;
  int          wr_count = 0;
  int          rlast_edge = 0;
  int          cycle = 0;

  // Bookkeeping
  string       test_name;
  int          checks = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          errors_at_start = 0;

  cache_top cache_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // ======================================================================
  // Helpers
  // ======================================================================

  // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Draws n stimulus bits with one LFSR step per bit
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      v = {v[30:0], stim_lfsr[0]};
    end
  endtask

  task automatic resp_bit(output logic b);
    resp_lfsr = lfsr_step(resp_lfsr);
    b = resp_lfsr[0];
  endtask

  // Initial memory contents depend on every address bit
  function automatic word_t fill_pattern(input int unsigned widx);
    word_t a;
    a = word_t'(widx) << 2;
    return (a * 32'h9E37_79B1) ^ {a[15:0], ~a[15:0]};
  endfunction

  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input strb_t s);
    word_t r;
    r = old_w;
    for (int b = 0; b < 4; b++) begin
      if (s[b]) begin
        r[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return r;
  endfunction

  task automatic check_word(input string what, input word_t exp, input word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_addr(input string what, input cache_addr_u exp, input cache_addr_u act);
    checks++;
    if (exp.raw !== act.raw) begin
      errors++;
      $display("mismatch %s %s: expected %h actual %h", test_name, what, exp.raw, act.raw);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch %s %s: expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errors - errors_at_start);
    end else begin
      $display("test %s: ok", test_name);
    end
  endtask

  // ======================================================================
  // CPU transactions with model prediction
  // ======================================================================

  // served_hit is set when the DUT answered without an AR
  task automatic read_word(input word_t addr, output logic served_hit);
    cache_addr_u a;
    cache_addr_u line;
    word_t       exp;
    int          ar_before;
    logic        pred_hit;
    logic        first_valid;
    logic        busy_rd_ready;
    a.raw = addr;
    line.raw = addr & ~word_t'(LINE_BYTES - 1);
    pred_hit = shadow_valid[a.f.set] && (shadow_tag[a.f.set] == a.f.tag);
    exp = model_mem[addr[10:2]];
    ar_before = ar_count;
    i_rd_valid = 1'b1;
    i_rd_addr = a;
    @(negedge clk);
    while (!o_rd_ready) @(negedge clk);
    // Accepted at this edge
    @(posedge clk);
    #1;
    i_rd_valid = 1'b0;
    @(negedge clk);
    first_valid = o_rd_data_valid;
    busy_rd_ready = o_rd_ready;
    while (!o_rd_data_valid) @(negedge clk);
    check_word("read data", exp, o_rd_data);
    check_bit("ar issued", !pred_hit, ar_count != ar_before);
    check_bit("rready after response", 1'b0, o_rready);
    if (pred_hit) begin
      check_bit("hit latency", 1'b1, first_valid);
      check_bit("rd_ready after hit", 1'b1, busy_rd_ready);
    end else begin
      check_bit("rd_ready during fill", 1'b0, busy_rd_ready);
      check_bit("single ar", 1'b1, ar_count == ar_before + 1);
      check_addr("araddr", line, last_araddr);
      check_bit("response after rlast", 1'b1, cycle == rlast_edge);
      shadow_valid[a.f.set] = 1'b1;
      shadow_tag[a.f.set] = a.f.tag;
    end
    served_hit = (ar_count == ar_before);
    @(posedge clk);
    #1;
  endtask

  task automatic write_word(input word_t addr, input word_t data, input strb_t strb);
    cache_addr_u a;
    logic        hit;
    int          wr_before;
    a.raw = addr;
    hit = shadow_valid[a.f.set] && (shadow_tag[a.f.set] == a.f.tag);
    wr_before = wr_count;
    i_wr_valid = 1'b1;
    i_wr_addr = a;
    i_wr_data = data;
    i_wr_strb = strb;
    @(negedge clk);
    while (!o_wr_ready) @(negedge clk);
    @(posedge clk);
    #1;
    i_wr_valid = 1'b0;
    check_bit("single aw/w", 1'b1, wr_count == wr_before + 1);
    check_addr("awaddr", a, last_awaddr);
    check_word("wdata", data, last_wdata);
    check_word("wstrb", word_t'(strb), word_t'(last_wstrb));
    model_mem[addr[10:2]] = merge_bytes(model_mem[addr[10:2]], data, strb);
    // Partial hit drops the line
    if (hit && (strb != FULL_STRB)) begin
      shadow_valid[a.f.set] = 1'b0;
    end
  endtask

  // ======================================================================
  // AXI memory responder
  // ======================================================================

  // Samples handshakes at the falling edge and drives just after the rising edge
  initial begin
    logic b;
    resp_lfsr = 16'd62;
    i_arready = 1'b0;
    i_rvalid = 1'b0;
    i_rdata = '0;
    i_rlast = 1'b0;
    i_awready = 1'b0;
    i_wready = 1'b0;
    burst_on = 1'b0;
    burst_line = '0;
    beat_idx = '0;
    aw_seen = 1'b0;
    w_seen = 1'b0;
    forever begin
      @(negedge clk);
      r_taken = rst_n && i_rvalid && o_rready;
      if (r_taken) begin
        if (i_rlast) begin
          burst_on = 1'b0;
          rlast_edge = cycle + 1;
        end
        beat_idx = beat_idx + 1'b1;
      end
      if (rst_n && o_arvalid && i_arready) begin
        ar_count++;
        last_araddr = o_araddr;
        burst_line = o_araddr.raw[10:2];
        beat_idx = '0;
        burst_on = 1'b1;
      end
      if (rst_n && o_awvalid && i_awready) begin
        aw_seen = 1'b1;
        last_awaddr = o_awaddr;
      end
      if (rst_n && o_wvalid && i_wready) begin
        w_seen = 1'b1;
        last_wdata = o_wdata;
        last_wstrb = o_wstrb;
      end
      // Single-beat write lands once both channels are in
      if (aw_seen && w_seen) begin
        axi_mem[last_awaddr.raw[10:2]] =
          merge_bytes(axi_mem[last_awaddr.raw[10:2]], last_wdata, last_wstrb);
        wr_count++;
        aw_seen = 1'b0;
        w_seen = 1'b0;
      end
      @(posedge clk);
      #1;
      resp_bit(b);
      i_arready = b;
      resp_bit(b);
      i_awready = b;
      resp_bit(b);
      i_wready = b;
      // rvalid holds until its beat is taken
      if (!burst_on) begin
        i_rvalid = 1'b0;
        i_rlast = 1'b0;
      end else if (!i_rvalid || r_taken) begin
        resp_bit(b);
        i_rvalid = b;
        i_rdata = axi_mem[{burst_line[8:2], beat_idx}];
        i_rlast = (int'(beat_idx) == BURST_BEATS - 1);
      end
    end
  end

  // ======================================================================
  // Tests
  // ======================================================================

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] f;
    logic [31:0] s;
    logic        hit;
    stim_lfsr = 16'd62;
    rst_n = 1'b0;
    i_rd_valid = 1'b0;
    i_rd_addr = '0;
    i_wr_valid = 1'b0;
    i_wr_addr = '0;
    i_wr_data = '0;
    i_wr_strb = '0;
    for (int i = 0; i < WINDOW_WORDS; i++) begin
      model_mem[i] = fill_pattern(i);
      axi_mem[i] = fill_pattern(i);
    end
    for (int i = 0; i < NUM_SETS; i++) begin
      shadow_valid[i] = 1'b0;
      shadow_tag[i] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test("reset_values");
    @(negedge clk);
    check_bit("arvalid", 1'b0, o_arvalid);
    check_bit("awvalid", 1'b0, o_awvalid);
    check_bit("wvalid", 1'b0, o_wvalid);
    check_bit("rd_data_valid", 1'b0, o_rd_data_valid);
    check_bit("wr_ready", 1'b0, o_wr_ready);
    @(posedge clk);
    #1;
    end_test();

    // Word addresses over 2 KiB give two tags per set
    start_test("random_traffic");
    for (int n = 0; n < NUM_TXN; n++) begin
      draw_bits(1, r);
      draw_bits(9, a);
      if (r[0]) begin
        draw_bits(32, d);
        draw_bits(1, f);
        draw_bits(4, s);
        write_word({21'b0, a[8:0], 2'b00}, d, f[0] ? FULL_STRB : s[3:0]);
      end else begin
        read_word({21'b0, a[8:0], 2'b00}, hit);
      end
    end
    end_test();

    start_test("write_then_read");
    read_word(32'h0000_0154, hit);
    write_word(32'h0000_0154, 32'hC0FF_EE01, FULL_STRB);
    read_word(32'h0000_0154, hit);
    check_bit("still cached", 1'b1, hit);
    end_test();

    start_test("partial_write_invalidate");
    read_word(32'h0000_0268, hit);
    write_word(32'h0000_0268, 32'h1234_5678, 4'b0101);
    read_word(32'h0000_0268, hit);
    check_bit("refetch", 1'b0, hit);
    end_test();

    // Set 7 with tags 0 and 1
    start_test("set_conflict");
    for (int k = 0; k < 3; k++) begin
      read_word(32'h0000_0070, hit);
      check_bit("first tag miss", 1'b0, hit);
      read_word(32'h0000_0470, hit);
      check_bit("second tag miss", 1'b0, hit);
    end
    end_test();

    $display("tests %0d  failed %0d  checks %0d  errors %0d  assertion failures %0d",
             tests_run, tests_failed, checks, errors,
             cache_top_inst.cache_sva_inst.fail_count);
    if ((errors == 0) && (cache_top_inst.cache_sva_inst.fail_count == 0)) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- verif/cache_sva.sv
module cache_sva
  import cache_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        o_arvalid,
  input cache_addr_u o_araddr,
  input logic        i_arready,
  input logic        o_awvalid,
  input logic        i_awready,
  input logic        o_wvalid,
  input logic        i_wready,
  input logic        o_rd_data_valid
);

  // Count of failed assertions
  int fail_count = 0;

  // ======================================================================
  // AXI manager rules
  // ======================================================================

  // Burst starts on a line boundary
  ar_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    o_arvalid |-> (o_araddr.raw[OFFSET_W-1:0] == '0))
    else begin
      fail_count++;
      $error("araddr not line aligned");
    end

  // Valids hold until their ready
  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_arvalid && !i_arready |=> o_arvalid)
    else begin
      fail_count++;
      $error("arvalid dropped before arready");
    end

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_awvalid && !i_awready |=> o_awvalid)
    else begin
      fail_count++;
      $error("awvalid dropped before awready");
    end

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_wvalid && !i_wready |=> o_wvalid)
    else begin
      fail_count++;
      $error("wvalid dropped before wready");
    end

  // No response pulse out of reset
  rd_valid_reset: assert property (@(posedge clk)
    !rst_n |=> !o_rd_data_valid)
    else begin
      fail_count++;
      $error("rd_data_valid high after reset");
    end

endmodule

bind cache_top cache_sva cache_sva_inst (
  .clk             (clk),
  .rst_n           (rst_n),
  .o_arvalid       (o_arvalid),
  .o_araddr        (o_araddr),
  .i_arready       (i_arready),
  .o_awvalid       (o_awvalid),
  .i_awready       (i_awready),
  .o_wvalid        (o_wvalid),
  .i_wready        (i_wready),
  .o_rd_data_valid (o_rd_data_valid)
);

//--- logic/cache_top.sv
module cache_top
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // CPU read
  input  logic        i_rd_valid,
  input  cache_addr_u i_rd_addr,
  output logic        o_rd_ready,
  output word_t       o_rd_data,
  output logic        o_rd_data_valid,

  // CPU write
  input  logic        i_wr_valid,
  input  cache_addr_u i_wr_addr,
  input  word_t       i_wr_data,
  input  strb_t       i_wr_strb,
  output logic        o_wr_ready,

  // AXI read
  output logic        o_arvalid,
  output cache_addr_u o_araddr,
  input  logic        i_arready,
  input  logic        i_rvalid,
  input  word_t       i_rdata,
  input  logic        i_rlast,
  output logic        o_rready,

  // AXI write
  output logic        o_awvalid,
  output cache_addr_u o_awaddr,
  input  logic        i_awready,
  output logic        o_wvalid,
  output word_t       o_wdata,
  output strb_t       o_wstrb,
  input  logic        i_wready
);

  // ======================================================================
  // Internal wiring
  // ======================================================================

  logic  rd_hit;
  logic  wr_hit;
  word_t rd_word;
  word_t req_word;

  logic  miss_start;
  logic  beat;
  logic  fill_done;
  logic  wt_we;
  logic  invalidate;

  tag_t  fill_tag;
  set_t  fill_set;
  idx_t  fill_idx;
  word_t fill_word;

  // Tag and valid tables
  cache_tag_store cache_tag_store_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_rd_addr    (i_rd_addr),
    .i_wr_addr    (i_wr_addr),
    .i_fill_done  (fill_done),
    .i_fill_tag   (fill_tag),
    .i_fill_set   (fill_set),
    .i_invalidate (invalidate),
    .o_rd_hit     (rd_hit),
    .o_wr_hit     (wr_hit)
  );

  // Line words
  cache_data_store cache_data_store_inst (
    .clk         (clk),
    .i_rd_addr   (i_rd_addr),
    .i_fill_we   (beat),
    .i_fill_set  (fill_set),
    .i_fill_idx  (fill_idx),
    .i_fill_word (fill_word),
    .i_wt_we     (wt_we),
    .i_wr_addr   (i_wr_addr),
    .i_wr_data   (i_wr_data),
    .o_rd_word   (rd_word)
  );

  // Burst tracking
  cache_fill_unit cache_fill_unit_inst (
    .clk          (clk),
    .i_miss_start (miss_start),
    .i_rd_addr    (i_rd_addr),
    .i_beat       (beat),
    .i_rdata      (i_rdata),
    .o_fill_tag   (fill_tag),
    .o_fill_set   (fill_set),
    .o_fill_idx   (fill_idx),
    .o_fill_word  (fill_word),
    .o_req_word   (req_word)
  );

  // FSM, AXI valids and CPU responses
  cache_ctrl cache_ctrl_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_rd_valid      (i_rd_valid),
    .i_wr_valid      (i_wr_valid),
    .i_wr_addr       (i_wr_addr),
    .i_wr_data       (i_wr_data),
    .i_wr_strb       (i_wr_strb),
    .i_rd_addr       (i_rd_addr),
    .i_rd_hit        (rd_hit),
    .i_wr_hit        (wr_hit),
    .i_rd_word       (rd_word),
    .i_req_word      (req_word),
    .i_arready       (i_arready),
    .i_rvalid        (i_rvalid),
    .i_rlast         (i_rlast),
    .i_awready       (i_awready),
    .i_wready        (i_wready),
    .o_miss_start    (miss_start),
    .o_beat          (beat),
    .o_fill_done     (fill_done),
    .o_wt_we         (wt_we),
    .o_invalidate    (invalidate),
    .o_rd_ready      (o_rd_ready),
    .o_rd_data       (o_rd_data),
    .o_rd_data_valid (o_rd_data_valid),
    .o_wr_ready      (o_wr_ready),
    .o_arvalid       (o_arvalid),
    .o_araddr        (o_araddr),
    .o_rready        (o_rready),
    .o_awvalid       (o_awvalid),
    .o_awaddr        (o_awaddr),
    .o_wvalid        (o_wvalid),
    .o_wdata         (o_wdata),
    .o_wstrb         (o_wstrb)
  );

endmodule

//--- logic/cache_ctrl.sv
module cache_ctrl
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // CPU side
  input  logic        i_rd_valid,
  input  logic        i_wr_valid,
  input  cache_addr_u i_wr_addr,
  input  word_t       i_wr_data,
  input  strb_t       i_wr_strb,
  input  cache_addr_u i_rd_addr,

  // Lookup results
  input  logic        i_rd_hit,
  input  logic        i_wr_hit,
  input  word_t       i_rd_word,
  input  word_t       i_req_word,

  // AXI handshakes in
  input  logic        i_arready,
  input  logic        i_rvalid,
  input  logic        i_rlast,
  input  logic        i_awready,
  input  logic        i_wready,

  // Store steering
  output logic        o_miss_start,
  output logic        o_beat,
  output logic        o_fill_done,
  output logic        o_wt_we,
  output logic        o_invalidate,

  // CPU responses
  output logic        o_rd_ready,
  output word_t       o_rd_data,
  output logic        o_rd_data_valid,
  output logic        o_wr_ready,

  // AXI manager
  output logic        o_arvalid,
  output cache_addr_u o_araddr,
  output logic        o_rready,
  output logic        o_awvalid,
  output cache_addr_u o_awaddr,
  output logic        o_wvalid,
  output word_t       o_wdata,
  output strb_t       o_wstrb
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ_BURST,
    ST_WRITE
  } state_t;

  state_t state;
  state_t state_next;

  logic wr_start;
  logic rd_hit_acc;
  logic aw_done;
  logic w_done;
  logic aw_complete;
  logic w_complete;
  logic rd_data_valid_next;

  // ======================================================================
  // Request decode
  // ======================================================================

  // Read wins if both were ever raised
  assign o_miss_start = (state == ST_IDLE) && i_rd_valid && !i_rd_hit;
  assign wr_start     = (state == ST_IDLE) && i_wr_valid && !i_rd_valid;
  assign rd_hit_acc   = i_rd_valid && o_rd_ready && i_rd_hit;

  // Full-word hit goes into the line, partial hit drops it
  assign o_wt_we      = wr_start && i_wr_hit && (i_wr_strb == FULL_STRB);
  assign o_invalidate = wr_start && i_wr_hit && (i_wr_strb != FULL_STRB);

  // R channel is open only during the burst
  assign o_rready    = (state == ST_READ_BURST);
  assign o_beat      = i_rvalid && o_rready;
  assign o_fill_done = o_beat && i_rlast;

  // Channel done, either earlier or on this edge
  assign aw_complete = aw_done || (o_awvalid && i_awready);
  assign w_complete  = w_done || (o_wvalid && i_wready);

  // ======================================================================
  // State machine
  // ======================================================================

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (o_miss_start) begin
          state_next = ST_READ_BURST;
        end else if (wr_start) begin
          state_next = ST_WRITE;
        end
      end
      ST_READ_BURST: begin
        if (o_fill_done) begin
          state_next = ST_IDLE;
        end
      end
      ST_WRITE: begin
        if (aw_complete && w_complete) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ======================================================================
  // AXI valids and addresses
  // ======================================================================

  // Valids rise after the request edge and drop after their own handshake
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_arvalid <= 1'b0;
      o_awvalid <= 1'b0;
      o_wvalid  <= 1'b0;
    end else begin
      o_arvalid <= o_miss_start || (o_arvalid && !i_arready);
      o_awvalid <= wr_start || (o_awvalid && !i_awready);
      o_wvalid  <= wr_start || (o_wvalid && !i_wready);
    end
  end

  // Line-aligned burst start
  always_ff @(posedge clk) begin
    if (o_miss_start) begin
      o_araddr.raw <= {i_rd_addr.raw[31:OFFSET_W], {OFFSET_W{1'b0}}};
    end
  end

  // CPU holds the write until o_wr_ready
  assign o_awaddr = i_wr_addr;
  assign o_wdata  = i_wr_data;
  assign o_wstrb  = i_wr_strb;

  // Sticky completion flags, cleared when a write starts
  always_ff @(posedge clk) begin
    if (!rst_n || wr_start) begin
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      aw_done <= aw_complete;
      w_done  <= w_complete;
    end
  end

  // ======================================================================
  // CPU responses
  // ======================================================================

  // A hit may slip in during a write, never during a fill
  assign o_rd_ready = (state == ST_IDLE) || ((state == ST_WRITE) && i_rd_hit);
  assign o_wr_ready = (state == ST_WRITE) && aw_complete && w_complete;

  assign rd_data_valid_next = rd_hit_acc || o_fill_done;

  // Fill word on completion, stored word on a hit
  always_ff @(posedge clk) begin
    if (rd_data_valid_next) begin
      o_rd_data <= o_fill_done ? i_req_word : i_rd_word;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_rd_data_valid <= 1'b0;
    end else begin
      o_rd_data_valid <= rd_data_valid_next;
    end
  end

endmodule

//--- logic/cache_fill_unit.sv
module cache_fill_unit
  import cache_pkg::*;
(
  input  logic        clk,

  // Miss taken this cycle
  input  logic        i_miss_start,
  input  cache_addr_u i_rd_addr,

  // R beat accepted this cycle
  input  logic        i_beat,
  input  word_t       i_rdata,

  // Line target for the tag and data stores
  output tag_t        o_fill_tag,
  output set_t        o_fill_set,
  output idx_t        o_fill_idx,
  output word_t       o_fill_word,

  // Word the CPU asked for
  output word_t       o_req_word
);

  // ======================================================================
  // Miss address capture
  // ======================================================================

  // Held for the whole burst
  // rd_addr is free to change after the miss handshake
  tag_t  miss_tag;
  set_t  miss_set;
  idx_t  miss_idx;

  // Word index of the next beat
  idx_t  beat_idx;

  // Requested word, once its beat has passed
  word_t req_word_q;

  // Current beat carries the requested word
  logic  req_beat;

  always_ff @(posedge clk) begin
    if (i_miss_start) begin
      miss_tag <= i_rd_addr.f.tag;
      miss_set <= i_rd_addr.f.set;
      miss_idx <= i_rd_addr.f.idx;
    end
  end

  // ======================================================================
  // Beat indexing
  // ======================================================================

  // Incrementing burst starts at word 0 of the line
  always_ff @(posedge clk) begin
    if (i_miss_start) begin
      beat_idx <= '0;
    end else if (i_beat) begin
      beat_idx <= beat_idx + 1'b1;
    end
  end

  assign req_beat = i_beat && (beat_idx == miss_idx);

  // Grab the requested word as it goes by
  always_ff @(posedge clk) begin
    if (req_beat) begin
      req_word_q <= i_rdata;
    end
  end

  // ======================================================================
  // Outputs
  // ======================================================================

  assign o_fill_tag  = miss_tag;
  assign o_fill_set  = miss_set;
  assign o_fill_idx  = beat_idx;
  assign o_fill_word = i_rdata;

  // Bypass when the last beat is the requested one
  assign o_req_word  = req_beat ? i_rdata : req_word_q;

endmodule

//--- logic/cache_data_store.sv
module cache_data_store
  import cache_pkg::*;
(
  input  logic        clk,

  // Lookup side
  input  cache_addr_u i_rd_addr,

  // Fill beat write
  input  logic        i_fill_we,
  input  set_t        i_fill_set,
  input  idx_t        i_fill_idx,
  input  word_t       i_fill_word,

  // Write-through of a full-word hit
  input  logic        i_wt_we,
  input  cache_addr_u i_wr_addr,
  input  word_t       i_wr_data,

  output word_t       o_rd_word
);

  // Flat word array, {set, word index}
  word_t mem [NUM_SETS * WORDS_PER_LINE];

  // Shared write port
  logic [SET_W+IDX_W-1:0] wr_sel;
  word_t                  wr_word;

  // ======================================================================
  // Write port select
  // ======================================================================

  // Fill beat has priority over write-through
  assign wr_sel  = i_fill_we ? {i_fill_set, i_fill_idx} :
                               {i_wr_addr.f.set, i_wr_addr.f.idx};
  assign wr_word = i_fill_we ? i_fill_word : i_wr_data;

  always_ff @(posedge clk) begin
    if (i_fill_we || i_wt_we) begin
      mem[wr_sel] <= wr_word;
    end
  end

  // Asynchronous read of the requested word
  assign o_rd_word = mem[{i_rd_addr.f.set, i_rd_addr.f.idx}];

endmodule

//--- logic/cache_tag_store.sv
module cache_tag_store
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // Lookup addresses
  input  cache_addr_u i_rd_addr,
  input  cache_addr_u i_wr_addr,

  // Line fill completion
  input  logic        i_fill_done,
  input  tag_t        i_fill_tag,
  input  set_t        i_fill_set,

  // Partial write hit
  input  logic        i_invalidate,

  output logic        o_rd_hit,
  output logic        o_wr_hit
);

  // ======================================================================
  // Tables
  // ======================================================================

  // One tag and one valid bit per set
  tag_t                tag_table [NUM_SETS];
  logic [NUM_SETS-1:0] valid_table;

  // Tag of the read address's set
  tag_t rd_tag;
  // Tag of the write address's set
  tag_t wr_tag;

  // ======================================================================
  // Hit compare
  // ======================================================================

  assign rd_tag = tag_table[i_rd_addr.f.set];
  assign wr_tag = tag_table[i_wr_addr.f.set];

  assign o_rd_hit = valid_table[i_rd_addr.f.set] && (rd_tag == i_rd_addr.f.tag);
  assign o_wr_hit = valid_table[i_wr_addr.f.set] && (wr_tag == i_wr_addr.f.tag);

  // ======================================================================
  // Table updates
  // ======================================================================

  // Valid bits
  // Invalidation wins over a fill in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_table <= '0;
    end else if (i_invalidate) begin
      valid_table[i_wr_addr.f.set] <= 1'b0;
    end else if (i_fill_done) begin
      valid_table[i_fill_set] <= 1'b1;
    end
  end

  // Tag is written once the whole line is in
  always_ff @(posedge clk) begin
    if (i_fill_done && !i_invalidate) begin
      tag_table[i_fill_set] <= i_fill_tag;
    end
  end

endmodule

//--- logic/cache_pkg.sv
package cache_pkg;

  // ======================================================================
  // Cache geometry
  // ======================================================================

  // 1 KiB direct-mapped, 16-byte lines
  localparam int CACHE_BYTES    = 1024;
  localparam int LINE_BYTES     = 16;
  localparam int NUM_SETS       = CACHE_BYTES / LINE_BYTES;
  localparam int WORDS_PER_LINE = LINE_BYTES / 4;

  // Address field widths
  localparam int OFFSET_W = $clog2(LINE_BYTES);
  localparam int SET_W    = $clog2(NUM_SETS);
  localparam int TAG_W    = 32 - SET_W - OFFSET_W;
  localparam int IDX_W    = $clog2(WORDS_PER_LINE);

  // One 32-bit word per beat, so a line is one 4-beat burst
  localparam int BURST_BEATS = WORDS_PER_LINE;

  // Strobe of a full-word write
  localparam logic [3:0] FULL_STRB = 4'b1111;

  // ======================================================================
  // Types
  // ======================================================================

  typedef logic [31:0] word_t;
  typedef logic [3:0] strb_t;

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [SET_W-1:0] set_t;
  typedef logic [IDX_W-1:0] idx_t;

  // Byte address seen two ways
  // raw for AXI and line alignment, f for the lookup fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      tag_t                        tag;
      set_t                        set;
      idx_t                        idx;
      logic [OFFSET_W-IDX_W-1:0]   byte_sel;
    } f;
  } cache_addr_u;

endpackage
